//--- modrm_defs.svh
`ifndef MODRM_DEFS_SVH
`define MODRM_DEFS_SVH

// --------------------------------------------------
// Prefetch FIFO geometry.
// --------------------------------------------------
`define MODRM_FIFO_DEPTH 8
`define MODRM_FIFO_PTR_W 3 // log2 of the depth.

// --------------------------------------------------
// Datapath widths.
// --------------------------------------------------
`define MODRM_BYTE_W 8
`define MODRM_WORD_W 16

`endif

//--- modrm_pkg.sv
`include "modrm_defs.svh"

package modrm_pkg;

    // General registers, in reg/rm field order.
    typedef enum logic [2:0] {
        AX = 3'd0,
        CX = 3'd1,
        DX = 3'd2,
        BX = 3'd3,
        SP = 3'd4,
        BP = 3'd5,
        SI = 3'd6,
        DI = 3'd7
    } gpr_t;

    // Instruction stream byte.
    typedef logic [`MODRM_BYTE_W-1:0] byte_t;

    // Register value, displacement or address.
    typedef logic [`MODRM_WORD_W-1:0] word_t;

endpackage

//--- byte_fifo.sv
`include "modrm_defs.svh"

module byte_fifo (
    input  logic             clk,
    input  logic             reset,
    // Write side.
    input  logic             wr_en,
    input  modrm_pkg::byte_t wr_data,
    output logic             full,
    // Shared read side.
    input  logic             modrm_rd_en,
    input  logic             immed_rd_en,
    output modrm_pkg::byte_t rd_data,
    output logic             empty
);

    typedef logic [`MODRM_FIFO_PTR_W-1:0] ptr_t;
    typedef logic [`MODRM_FIFO_PTR_W:0]   count_t;

    modrm_pkg::byte_t mem [`MODRM_FIFO_DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    count_t           count;
    logic             push;
    logic             pop;

    assign full  = count == count_t'(`MODRM_FIFO_DEPTH);
    assign empty = count == '0;

    assign push = wr_en & ~full;
    assign pop  = (modrm_rd_en | immed_rd_en) & ~empty; // Either reader pops.

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(`MODRM_FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // --------------------------------------------------
    // Pointers and occupancy.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Storage and registered head byte.
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
        if (pop)
            rd_data <= mem[rd_ptr]; // Held until the next pop.
    end

endmodule

//--- register_file.sv
module register_file (
    input  logic             clk,
    input  logic             reset,
    // Write port.
    input  logic             wr_en,
    input  modrm_pkg::gpr_t  wr_sel,
    input  modrm_pkg::word_t wr_data,
    // Address read ports.
    input  modrm_pkg::gpr_t  base_sel,
    input  modrm_pkg::gpr_t  index_sel,
    output modrm_pkg::word_t base_value,
    output modrm_pkg::word_t index_value
);

    modrm_pkg::word_t regs [8];

    // --------------------------------------------------
    // Register array.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wr_sel] <= wr_data;
    end

    // Combinational reads for the address adder.
    assign base_value  = regs[base_sel];
    assign index_value = regs[index_sel];

endmodule

//--- immediate_reader.sv
module immediate_reader (
    input  logic             clk,
    input  logic             reset,
    // Control.
    input  logic             start,
    input  logic             is_8bit,
    // FIFO read port.
    output logic             rd_en,
    input  modrm_pkg::byte_t rd_data,
    input  logic             empty,
    // Result.
    output logic             complete,
    output modrm_pkg::word_t immediate
);

    logic             active;
    logic [1:0]       remaining;  // Bytes still to pop.
    logic [1:0]       to_pop;
    logic             popped;     // Byte on rd_data this cycle.
    logic             high_next;
    logic             done;
    modrm_pkg::byte_t low_byte;
    modrm_pkg::byte_t high_byte;

    // Byte count is loaded on the first cycle of start.
    assign to_pop = active ? remaining : (is_8bit ? 2'd1 : 2'd2);
    assign rd_en  = start & ~empty & (to_pop != 2'd0);

    // --------------------------------------------------
    // Pop counter.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            remaining <= 2'd0;
        end else if (!start) begin
            active    <= 1'b0;
            remaining <= 2'd0;
        end else begin
            active    <= 1'b1;
            remaining <= to_pop - {1'b0, rd_en};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            popped <= 1'b0;
        else
            popped <= rd_en;
    end

    // --------------------------------------------------
    // Arrival tracking.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            high_next <= 1'b0;
            done      <= 1'b0;
        end else if (!start) begin
            high_next <= 1'b0;
            done      <= 1'b0;
        end else if (popped) begin
            high_next <= 1'b1;
            if (high_next || is_8bit)
                done <= 1'b1; // Last byte in.
        end
    end

    always_ff @(posedge clk) begin
        if (popped) begin
            if (high_next)
                high_byte <= rd_data;
            else
                low_byte <= rd_data;
        end
    end

    assign complete  = start & done;
    assign immediate = is_8bit ? {{8{low_byte[7]}}, low_byte} : {high_byte, low_byte};

endmodule

//--- modrm_decode.sv
module modrm_decode (
    input  logic             clk,
    input  logic             reset,
    // Control.
    input  logic             start,
    output logic             busy,
    output logic             complete,
    // Results.
    output modrm_pkg::word_t effective_address,
    output modrm_pkg::gpr_t  regnum,
    output logic             rm_is_reg,
    output modrm_pkg::gpr_t  rm_regnum,
    // Register file.
    output modrm_pkg::gpr_t  base_sel,
    output modrm_pkg::gpr_t  index_sel,
    input  modrm_pkg::word_t base_value,
    input  modrm_pkg::word_t index_value,
    // FIFO read port.
    output logic             fifo_rd_en,
    input  modrm_pkg::byte_t fifo_rd_data,
    input  logic             fifo_empty,
    // Displacement reader.
    output logic             immed_start,
    input  logic             immed_complete,
    output logic             immed_is_8bit,
    input  modrm_pkg::word_t immediate
);

    logic             popped;     // ModR/M byte on fifo_rd_data.
    logic             have_modrm; // ModR/M byte held in modrm.
    logic             fetched;
    modrm_pkg::byte_t modrm;
    modrm_pkg::byte_t modrm_byte;
    logic [1:0]       mod_field;
    logic [2:0]       reg_field;
    logic [2:0]       rm_field;
    logic             has_address;
    logic             has_disp;
    logic             has_index;
    modrm_pkg::word_t index_term;
    modrm_pkg::word_t disp_term;

    // --------------------------------------------------
    // ModR/M fetch.
    // --------------------------------------------------
    assign fetched    = popped | have_modrm;
    assign fifo_rd_en = start & ~fifo_empty & ~fetched;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            popped <= 1'b0;
        else
            popped <= fifo_rd_en;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            have_modrm <= 1'b0;
        else if (!start)
            have_modrm <= 1'b0;
        else if (popped)
            have_modrm <= 1'b1;
    end

    // Kept, since the displacement pops overwrite rd_data.
    always_ff @(posedge clk) begin
        if (popped)
            modrm <= fifo_rd_data;
    end

    assign modrm_byte = popped ? fifo_rd_data : modrm;
    assign mod_field  = modrm_byte[7:6];
    assign reg_field  = modrm_byte[5:3];
    assign rm_field   = modrm_byte[2:0];

    assign has_address = mod_field != 2'b11;
    assign has_index   = ~rm_field[2]; // rm 0..3 use two registers.

    always_comb begin
        case (mod_field)
            2'b00:   has_disp = rm_field == 3'b110; // Direct address.
            2'b01:   has_disp = 1'b1;
            2'b10:   has_disp = 1'b1;
            default: has_disp = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Handshake.
    // --------------------------------------------------
    assign complete = start & (has_address ? have_modrm & (~has_disp | immed_complete)
                                           : fetched);
    assign busy          = start & ~complete;
    assign immed_start   = start & fetched & has_disp;
    assign immed_is_8bit = mod_field == 2'b01;

    // --------------------------------------------------
    // Register selection and address adder.
    // --------------------------------------------------
    always_comb begin
        case (rm_field)
            3'b000, 3'b001, 3'b111: base_sel = modrm_pkg::BX;
            3'b010, 3'b011, 3'b110: base_sel = modrm_pkg::BP;
            3'b100:                 base_sel = modrm_pkg::SI;
            default:                base_sel = modrm_pkg::DI;
        endcase

        case (rm_field)
            3'b000, 3'b010: index_sel = modrm_pkg::SI;
            3'b001, 3'b011: index_sel = modrm_pkg::DI;
            default:        index_sel = modrm_pkg::AX; // Not added.
        endcase
    end

    always_comb begin
        index_term = has_index ? index_value : '0;
        disp_term  = has_disp ? immediate : '0;

        if (mod_field == 2'b00 && rm_field == 3'b110)
            effective_address = immediate;
        else if (has_address)
            effective_address = base_value + index_term + disp_term; // Wraps at 16 bits.
        else
            effective_address = '0;
    end

    assign regnum    = modrm_pkg::gpr_t'(reg_field);
    assign rm_regnum = modrm_pkg::gpr_t'(rm_field);
    assign rm_is_reg = ~has_address;

endmodule

//--- modrm_unit.sv
module modrm_unit (
    input  logic             clk,
    input  logic             reset,
    // Instruction byte input.
    input  logic             wr_en,
    input  modrm_pkg::byte_t wr_data,
    output logic             full,
    // Register load port.
    input  logic             reg_wr_en,
    input  modrm_pkg::gpr_t  reg_wr_sel,
    input  modrm_pkg::word_t reg_wr_data,
    // Control.
    input  logic             start,
    output logic             busy,
    output logic             complete,
    // Results.
    output modrm_pkg::word_t effective_address,
    output modrm_pkg::gpr_t  regnum,
    output logic             rm_is_reg,
    output modrm_pkg::gpr_t  rm_regnum
);

    logic             modrm_rd_en;
    logic             immed_rd_en;
    modrm_pkg::byte_t rd_data;
    logic             empty;

    modrm_pkg::gpr_t  base_sel;
    modrm_pkg::gpr_t  index_sel;
    modrm_pkg::word_t base_value;
    modrm_pkg::word_t index_value;

    logic             immed_start;
    logic             immed_complete;
    logic             immed_is_8bit;
    modrm_pkg::word_t immediate;

    // --------------------------------------------------
    // Prefetch FIFO and registers.
    // --------------------------------------------------
    byte_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .full        (full),
        .modrm_rd_en (modrm_rd_en),
        .immed_rd_en (immed_rd_en),
        .rd_data     (rd_data),
        .empty       (empty)
    );

    register_file u_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (reg_wr_en),
        .wr_sel      (reg_wr_sel),
        .wr_data     (reg_wr_data),
        .base_sel    (base_sel),
        .index_sel   (index_sel),
        .base_value  (base_value),
        .index_value (index_value)
    );

    // --------------------------------------------------
    // Displacement reader and decoder.
    // --------------------------------------------------
    immediate_reader u_immed (
        .clk       (clk),
        .reset     (reset),
        .start     (immed_start),
        .is_8bit   (immed_is_8bit),
        .rd_en     (immed_rd_en),
        .rd_data   (rd_data),
        .empty     (empty),
        .complete  (immed_complete),
        .immediate (immediate)
    );

    modrm_decode u_decode (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .busy              (busy),
        .complete          (complete),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_is_reg         (rm_is_reg),
        .rm_regnum         (rm_regnum),
        .base_sel          (base_sel),
        .index_sel         (index_sel),
        .base_value        (base_value),
        .index_value       (index_value),
        .fifo_rd_en        (modrm_rd_en),
        .fifo_rd_data      (rd_data),
        .fifo_empty        (empty),
        .immed_start       (immed_start),
        .immed_complete    (immed_complete),
        .immed_is_8bit     (immed_is_8bit),
        .immediate         (immediate)
    );

endmodule

//--- modrm_tb_cases.svh
`ifndef MODRM_TB_CASES_SVH
`define MODRM_TB_CASES_SVH

// Each case gives name, BX, BP, SI, DI, ModR/M byte, displacement bytes and late push.
task automatic build_cases();
    logic [31:0]      r;
    modrm_pkg::byte_t modrm;

    // --------------------------------------------------
    // Register mode, every reg and rm.
    // --------------------------------------------------
    for (int m = 0; m < 64; m++) begin
        add_case($sformatf("reg_mode_%0d_%0d", m / 8, m % 8),
                 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                 modrm_pkg::byte_t'(8'hC0 + m), 16'h0000, 1'b0);
    end

    // --------------------------------------------------
    // Memory mode without displacement.
    // --------------------------------------------------
    add_case("mem_bx_si",      16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h00, 16'h0000, 1'b0);
    add_case("mem_bx_di",      16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h09, 16'h0000, 1'b0);
    add_case("mem_bp_si",      16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h12, 16'h0000, 1'b0);
    add_case("mem_bp_di",      16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h1B, 16'h0000, 1'b0);
    add_case("mem_si",         16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h24, 16'h0000, 1'b0);
    add_case("mem_di",         16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h2D, 16'h0000, 1'b0);
    add_case("mem_bx",         16'h1200, 16'h3400, 16'h0056, 16'h0078, 8'h3F, 16'h0000, 1'b0);
    add_case("mem_bx_si_wrap", 16'hFFF0, 16'h0000, 16'h0025, 16'h0000, 8'h00, 16'h0000, 1'b0);

    // Direct address, low byte first.
    add_case("direct_1234",    16'h1111, 16'h2222, 16'h3333, 16'h4444, 8'h06, 16'h1234, 1'b0);
    add_case("direct_fffe",    16'h1111, 16'h2222, 16'h3333, 16'h4444, 8'h3E, 16'hFFFE, 1'b0);

    // --------------------------------------------------
    // Displacement forms.
    // --------------------------------------------------
    add_case("disp8_pos",      16'h0100, 16'h0200, 16'h0030, 16'h0040, 8'h40, 16'h007F, 1'b0);
    add_case("disp8_neg",      16'h0100, 16'h0200, 16'h0030, 16'h0040, 8'h46, 16'h0080, 1'b0);
    add_case("disp8_neg_wrap", 16'h0010, 16'h0000, 16'h0000, 16'h0000, 8'h47, 16'h00F0, 1'b0);
    add_case("disp16_bx_di",   16'h1000, 16'h0000, 16'h0000, 16'h0203, 8'h81, 16'hABCD, 1'b0);
    add_case("disp16_bp_wrap", 16'h0000, 16'hFF00, 16'h0000, 16'h0000, 8'h96, 16'h0200, 1'b0);
    add_case("disp16_si",      16'h0000, 16'h0000, 16'h8000, 16'h0000, 8'h84, 16'h8001, 1'b0);

    // FIFO runs dry between the ModR/M byte and the displacement.
    add_case("late_disp16",    16'h0000, 16'h0500, 16'h0000, 16'h0060, 8'h83, 16'h4321, 1'b1);
    add_case("late_disp8",     16'h2000, 16'h0000, 16'h0000, 16'h0007, 8'h45, 16'h00FE, 1'b1);

    // --------------------------------------------------
    // Random memory forms.
    // --------------------------------------------------
    for (int i = 0; i < 8; i++) begin
        r     = $urandom;
        modrm = {(r[7:6] == 2'b11) ? 2'b10 : r[7:6], r[5:0]}; // Keep it a memory form.
        add_case($sformatf("random_%0d", i),
                 modrm_pkg::word_t'($urandom), modrm_pkg::word_t'($urandom),
                 modrm_pkg::word_t'($urandom), modrm_pkg::word_t'($urandom),
                 modrm, modrm_pkg::word_t'($urandom), 1'b0);
    end
endtask

`endif

//--- modrm_tb.sv
`include "modrm_defs.svh"

module modrm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATE_GAP = 3; // Cycles the FIFO is left empty.

    typedef struct {
        string            name;
        modrm_pkg::word_t bx;
        modrm_pkg::word_t bp;
        modrm_pkg::word_t si;
        modrm_pkg::word_t di;
        bit               late;
        int               nbytes;
        logic             exp_is_reg;
        modrm_pkg::gpr_t  exp_reg;
        modrm_pkg::gpr_t  exp_rm;
        modrm_pkg::word_t exp_ea;
    } case_t;

    logic             clk;
    logic             reset;
    logic             wr_en;
    modrm_pkg::byte_t wr_data;
    logic             full;
    logic             reg_wr_en;
    modrm_pkg::gpr_t  reg_wr_sel;
    modrm_pkg::word_t reg_wr_data;
    logic             start;
    logic             busy;
    logic             complete;
    modrm_pkg::word_t effective_address;
    modrm_pkg::gpr_t  regnum;
    logic             rm_is_reg;
    modrm_pkg::gpr_t  rm_regnum;

    case_t            cases[$];
    modrm_pkg::byte_t stream[$]; // All instruction bytes in order.
    int               held_at[$]; // Stream index where a late push waits.
    int               next_byte;
    int               done_bytes;
    int               cycle_count;

    modrm_unit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Failure reporting and checks.
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input string what,
                              input modrm_pkg::word_t exp, input modrm_pkg::word_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s %s: expected %h, actual %h", name, what, exp, act));
    endtask

    task automatic check_gpr(input string name, input string what,
                             input modrm_pkg::gpr_t exp, input modrm_pkg::gpr_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s %s: expected %0d, actual %0d", name, what, exp, act));
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s %s: expected %b, actual %b", name, what, exp, act));
    endtask

    // --------------------------------------------------
    // Reference model.
    // --------------------------------------------------
    function automatic int disp_length(input modrm_pkg::byte_t modrm);
        case (modrm[7:6])
            2'b00:   return (modrm[2:0] == 3'b110) ? 2 : 0;
            2'b01:   return 1;
            2'b10:   return 2;
            default: return 0;
        endcase
    endfunction

    function automatic modrm_pkg::word_t model_address(
        input modrm_pkg::byte_t modrm,
        input modrm_pkg::word_t disp,
        input modrm_pkg::word_t bx, bp, si, di
    );
        modrm_pkg::word_t offset;
        modrm_pkg::word_t sum;
        case (modrm[7:6])
            2'b01:   offset = {{8{disp[7]}}, disp[7:0]};
            2'b10:   offset = disp;
            default: offset = '0;
        endcase
        case (modrm[2:0])
            3'd0:    sum = bx + si;
            3'd1:    sum = bx + di;
            3'd2:    sum = bp + si;
            3'd3:    sum = bp + di;
            3'd4:    sum = si;
            3'd5:    sum = di;
            3'd6:    sum = (modrm[7:6] == 2'b00) ? disp : bp; // Direct address.
            default: sum = bx;
        endcase
        return sum + offset;
    endfunction

    task automatic add_case(input string name, input modrm_pkg::word_t bx, bp, si, di,
                            input modrm_pkg::byte_t modrm, input modrm_pkg::word_t disp,
                            input bit late);
        case_t c;
        int    n;
        n            = disp_length(modrm);
        c.name       = name;
        c.bx         = bx;
        c.bp         = bp;
        c.si         = si;
        c.di         = di;
        c.late       = late;
        c.nbytes     = n + 1;
        c.exp_is_reg = modrm[7:6] == 2'b11;
        c.exp_reg    = modrm_pkg::gpr_t'(modrm[5:3]);
        c.exp_rm     = modrm_pkg::gpr_t'(modrm[2:0]);
        c.exp_ea     = model_address(modrm, disp, bx, bp, si, di);
        if (late)
            held_at.push_back(stream.size() + 1);
        stream.push_back(modrm);
        if (n >= 1)
            stream.push_back(disp[7:0]);
        if (n == 2)
            stream.push_back(disp[15:8]);
        cases.push_back(c);
    endtask

    `include "modrm_tb_cases.svh"

    // --------------------------------------------------
    // Stimulus.
    // --------------------------------------------------
    task automatic feed_byte();
        if (full && next_byte - done_bytes < `MODRM_FIFO_DEPTH)
            abort_run("FIFO reports full with fewer bytes queued than its depth.");
        wr_en = 1'b0;
        if (next_byte < stream.size() && !full &&
            (held_at.size() == 0 || next_byte < held_at[0])) begin
            wr_en   = 1'b1;
            wr_data = stream[next_byte];
            next_byte++;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        feed_byte();
    endtask

    task automatic load_reg(input modrm_pkg::gpr_t sel, input modrm_pkg::word_t value);
        tick();
        reg_wr_en   = 1'b1;
        reg_wr_sel  = sel;
        reg_wr_data = value;
    endtask

    task automatic run_case(input case_t c);
        int waited;
        load_reg(modrm_pkg::BX, c.bx);
        load_reg(modrm_pkg::BP, c.bp);
        load_reg(modrm_pkg::SI, c.si);
        load_reg(modrm_pkg::DI, c.di);
        tick();
        reg_wr_en = 1'b0;
        start     = 1'b1;
        waited    = 0;
        tick();
        while (!complete) begin
            check_bit(c.name, "busy", 1'b1, busy);
            if (c.late && waited == LATE_GAP)
                void'(held_at.pop_front()); // Let the displacement in.
            waited++;
            tick();
        end
        check_bit(c.name, "busy", 1'b0, busy);
        check_bit(c.name, "rm_is_reg", c.exp_is_reg, rm_is_reg);
        check_gpr(c.name, "regnum", c.exp_reg, regnum);
        if (c.exp_is_reg)
            check_gpr(c.name, "rm_regnum", c.exp_rm, rm_regnum);
        else
            check_word(c.name, "effective_address", c.exp_ea, effective_address);
        done_bytes += c.nbytes;
        start = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h2fc3fd14));
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_data     = '0;
        reg_wr_en   = 1'b0;
        reg_wr_sel  = modrm_pkg::AX;
        reg_wr_data = '0;
        start       = 1'b0;
        next_byte   = 0;
        done_bytes  = 0;
        build_cases();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("reset", "busy", 1'b0, busy);
        check_bit("reset", "complete", 1'b0, complete);
        check_bit("reset", "full", 1'b0, full);
        // Nonzero values in the registers that no address form uses.
        load_reg(modrm_pkg::AX, 16'hA0A1);
        load_reg(modrm_pkg::CX, 16'hC0C1);
        load_reg(modrm_pkg::DX, 16'hD0D1);
        load_reg(modrm_pkg::SP, 16'h5051);
        for (int i = 0; i < cases.size(); i++)
            run_case(cases[i]);
        tick();
        check_bit("idle", "busy", 1'b0, busy);
        $display("NO ERRORS");
        $finish;
    end

    // Run limit grows with the table.
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cases.size() * 12 + 50)
                abort_run("Timeout, the run did not finish within its cycle limit.");
        end
    end

endmodule

//--- src.f
+incdir+.
modrm_pkg.sv
byte_fifo.sv
register_file.sv
immediate_reader.sv
modrm_decode.sv
modrm_unit.sv
modrm_tb.sv

//--- Makefile
TOP := modrm_tb

sim:
	verilator --binary --timing --top-module $(TOP) -f src.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
